// ==== verilog/img_gray_params.svh ====
`ifndef IMG_GRAY_PARAMS_SVH
`define IMG_GRAY_PARAMS_SVH

// Parallel lanes per group.
`define IMG_GRAY_LANES 4

`define IMG_GRAY_PIX_W 10
`define IMG_GRAY_CNT_W 20

// Fixed-point weights. Each term is (channel * weight) >> shift.
`define IMG_GRAY_W_RED    19
`define IMG_GRAY_W_GREEN  75
`define IMG_GRAY_W_BLUE   37
`define IMG_GRAY_SH_RED   6
`define IMG_GRAY_SH_GREEN 7
`define IMG_GRAY_SH_BLUE  8

// APB register offsets.
`define IMG_GRAY_ADDR_CTRL   8'h00
`define IMG_GRAY_ADDR_COUNT  8'h04
`define IMG_GRAY_ADDR_THRESH 8'h08
`define IMG_GRAY_ADDR_STATUS 8'h0C
`define IMG_GRAY_ADDR_DARK   8'h10

`endif

// ==== verilog/img_gray_pkg.sv ====
`include "img_gray_params.svh"

package img_gray_pkg;

    // Input pixel, one channel per field.
    typedef struct packed {
        logic [`IMG_GRAY_PIX_W-1:0] red;
        logic [`IMG_GRAY_PIX_W-1:0] green;
        logic [`IMG_GRAY_PIX_W-1:0] blue;
    } rgb_pixel_t;

    // Output pixel. bw is 1 for dark.
    typedef struct packed {
        logic [`IMG_GRAY_PIX_W-1:0] gray;
        logic                       bw;
        logic                       last;
    } gray_pixel_t;

    // Lane k carries the k-th pixel of the group.
    typedef rgb_pixel_t [`IMG_GRAY_LANES-1:0] lane_group_t;

    typedef struct packed {
        logic [`IMG_GRAY_LANES-1:0][`IMG_GRAY_PIX_W-1:0] gray;
        logic [`IMG_GRAY_LANES-1:0]                      bw;
    } gray_group_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// ==== verilog/img_gray_apb_regs.sv ====
`include "img_gray_params.svh"

module img_gray_apb_regs (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  img_gray_pkg::apb_req_t     i_apb,
    output img_gray_pkg::apb_rsp_t     o_apb,
    output logic                       o_start,
    output logic [`IMG_GRAY_CNT_W-1:0] o_pixel_count,
    output logic [`IMG_GRAY_PIX_W-1:0] o_threshold,
    input  logic                       i_frame_done,
    input  logic [`IMG_GRAY_CNT_W-1:0] i_dark_count
);

    logic                       access;
    logic                       wr_en;
    logic                       addr_ok;
    logic                       start_q;
    logic                       busy_q;
    logic                       done_q;
    logic [`IMG_GRAY_CNT_W-1:0] count_q;
    logic [`IMG_GRAY_PIX_W-1:0] thresh_q;
    logic [31:0]                rdata;

    // Access phase of a transfer; pready is tied high.
    assign access = i_apb.psel && i_apb.penable;
    assign wr_en  = access && i_apb.pwrite;

    //////////////////////////////////////////////////
    // Address decode and read mux.
    //////////////////////////////////////////////////

    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (i_apb.paddr)
            `IMG_GRAY_ADDR_CTRL:   rdata = '0;
            `IMG_GRAY_ADDR_COUNT:  rdata = 32'(count_q);
            `IMG_GRAY_ADDR_THRESH: rdata = 32'(thresh_q);
            `IMG_GRAY_ADDR_STATUS: rdata = {30'b0, done_q, busy_q};
            `IMG_GRAY_ADDR_DARK:   rdata = 32'(i_dark_count);
            default:               addr_ok = 1'b0;
        endcase
    end

    always_comb begin
        o_apb.prdata  = rdata;
        o_apb.pready  = 1'b1;
        o_apb.pslverr = access && !addr_ok;
    end

    //////////////////////////////////////////////////
    // Control and status.
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            start_q <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (wr_en && i_apb.paddr == `IMG_GRAY_ADDR_CTRL && i_apb.pwdata[0] && !busy_q) begin
                start_q <= 1'b1;
                busy_q  <= 1'b1;
                done_q  <= 1'b0;
            end else if (i_frame_done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // Frame setup is frozen while a frame runs.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count_q  <= '0;
            thresh_q <= '0;
        end else if (wr_en && !busy_q) begin
            if (i_apb.paddr == `IMG_GRAY_ADDR_COUNT) begin
                count_q <= i_apb.pwdata[`IMG_GRAY_CNT_W-1:0];
            end
            if (i_apb.paddr == `IMG_GRAY_ADDR_THRESH) begin
                thresh_q <= i_apb.pwdata[`IMG_GRAY_PIX_W-1:0];
            end
        end
    end

    assign o_start       = start_q;
    assign o_pixel_count = count_q;
    assign o_threshold   = thresh_q;

endmodule

// ==== verilog/img_gray_fetch.sv ====
`include "img_gray_params.svh"

module img_gray_fetch (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    input  logic [`IMG_GRAY_CNT_W-1:0]  i_pixel_count,
    input  img_gray_pkg::rgb_pixel_t    i_pix,
    input  logic                        i_pix_valid,
    output logic                        o_pix_ready,
    input  logic                        i_accept,
    output img_gray_pkg::lane_group_t   o_group,
    output logic                        o_group_valid,
    output logic                        o_group_last
);

    import img_gray_pkg::*;

    localparam int SLOT_W = (`IMG_GRAY_LANES > 1) ? $clog2(`IMG_GRAY_LANES) : 1;
    localparam logic [`IMG_GRAY_CNT_W-1:0] LANE_CNT = `IMG_GRAY_LANES;
    localparam logic [SLOT_W-1:0] SLOT_MAX = SLOT_W'(`IMG_GRAY_LANES - 1);

    logic [`IMG_GRAY_CNT_W-1:0] remain_q;
    logic [SLOT_W-1:0]          slot_q;
    logic                       slot_last;
    logic                       pix_fire;
    lane_group_t                fill_q;
    lane_group_t                full_group;
    lane_group_t                group_q;
    logic                       group_valid_q;
    logic                       group_last_q;

    assign slot_last = (slot_q == SLOT_MAX);

    // The closing pixel of a group needs the output register free or draining.
    assign o_pix_ready = (remain_q != '0) && (!slot_last || !group_valid_q || i_accept);
    assign pix_fire    = o_pix_ready && i_pix_valid;

    always_comb begin
        full_group         = fill_q;
        full_group[slot_q] = i_pix;
    end

    //////////////////////////////////////////////////
    // Frame counter and slot index.
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            remain_q <= '0;
            slot_q   <= '0;
        end else if (i_start) begin
            // Partial groups are dropped from the count.
            remain_q <= i_pixel_count - (i_pixel_count % LANE_CNT);
            slot_q   <= '0;
        end else if (pix_fire) begin
            remain_q <= remain_q - 1'b1;
            slot_q   <= slot_last ? '0 : slot_q + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (pix_fire) begin
            fill_q[slot_q] <= i_pix;
        end
        if (pix_fire && slot_last) begin
            group_q <= full_group;
        end
    end

    //////////////////////////////////////////////////
    // Group presented to the lanes.
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            group_valid_q <= 1'b0;
            group_last_q  <= 1'b0;
        end else if (pix_fire && slot_last) begin
            group_valid_q <= 1'b1;
            group_last_q  <= (remain_q == 1);
        end else if (i_accept) begin
            group_valid_q <= 1'b0;
            group_last_q  <= 1'b0;
        end
    end

    assign o_group       = group_q;
    assign o_group_valid = group_valid_q;
    assign o_group_last  = group_last_q;

endmodule

// ==== verilog/gray_lane.sv ====
`include "img_gray_params.svh"

module gray_lane (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_advance,
    input  img_gray_pkg::rgb_pixel_t    i_pix,
    input  logic [`IMG_GRAY_PIX_W-1:0]  i_threshold,
    output logic [`IMG_GRAY_PIX_W-1:0]  o_gray,
    output logic                        o_bw
);

    localparam int PROD_W = 2 * `IMG_GRAY_PIX_W;
    localparam int SUM_W  = `IMG_GRAY_PIX_W + 2;
    localparam logic [`IMG_GRAY_PIX_W-1:0] GRAY_MAX = {`IMG_GRAY_PIX_W{1'b1}};

    logic [PROD_W-1:0]          red_prod;
    logic [PROD_W-1:0]          green_prod;
    logic [PROD_W-1:0]          blue_prod;
    logic [`IMG_GRAY_PIX_W-1:0] red_q;
    logic [`IMG_GRAY_PIX_W-1:0] green_q;
    logic [`IMG_GRAY_PIX_W-1:0] blue_q;
    logic [SUM_W-1:0]           sum;
    logic [`IMG_GRAY_PIX_W-1:0] gray_sat;
    logic [`IMG_GRAY_PIX_W-1:0] gray_q;
    logic                       bw_q;

    assign red_prod   = PROD_W'(i_pix.red) * PROD_W'(`IMG_GRAY_W_RED);
    assign green_prod = PROD_W'(i_pix.green) * PROD_W'(`IMG_GRAY_W_GREEN);
    assign blue_prod  = PROD_W'(i_pix.blue) * PROD_W'(`IMG_GRAY_W_BLUE);

    // Each shifted term stays below 600, so it fits a channel width.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            red_q   <= '0;
            green_q <= '0;
            blue_q  <= '0;
        end else if (i_advance) begin
            red_q   <= `IMG_GRAY_PIX_W'(red_prod >> `IMG_GRAY_SH_RED);
            green_q <= `IMG_GRAY_PIX_W'(green_prod >> `IMG_GRAY_SH_GREEN);
            blue_q  <= `IMG_GRAY_PIX_W'(blue_prod >> `IMG_GRAY_SH_BLUE);
        end
    end

    assign sum      = SUM_W'(red_q) + SUM_W'(green_q) + SUM_W'(blue_q);
    assign gray_sat = (sum > SUM_W'(GRAY_MAX)) ? GRAY_MAX : sum[`IMG_GRAY_PIX_W-1:0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gray_q <= '0;
            bw_q   <= 1'b0;
        end else if (i_advance) begin
            gray_q <= gray_sat;
            bw_q   <= (gray_sat <= i_threshold);
        end
    end

    assign o_gray = gray_q;
    assign o_bw   = bw_q;

endmodule

// ==== verilog/img_gray_collect.sv ====
`include "img_gray_params.svh"

module img_gray_collect (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    input  img_gray_pkg::gray_group_t   i_group,
    input  logic                        i_group_valid,
    input  logic                        i_group_last,
    output logic                        o_accept,
    output img_gray_pkg::gray_pixel_t   o_gray,
    output logic                        o_gray_valid,
    input  logic                        i_gray_ready,
    output logic                        o_frame_done,
    output logic [`IMG_GRAY_CNT_W-1:0]  o_dark_count
);

    import img_gray_pkg::*;

    localparam int SLOT_W = (`IMG_GRAY_LANES > 1) ? $clog2(`IMG_GRAY_LANES) : 1;
    localparam logic [SLOT_W-1:0] SLOT_MAX = SLOT_W'(`IMG_GRAY_LANES - 1);

    logic                       vld1_q;
    logic                       vld2_q;
    logic                       last1_q;
    logic                       last2_q;
    gray_group_t                buf_q;
    logic                       buf_valid_q;
    logic                       buf_last_q;
    logic [SLOT_W-1:0]          idx_q;
    logic                       idx_last;
    logic                       out_fire;
    logic [`IMG_GRAY_CNT_W-1:0] dark_q;
    logic                       done_q;

    assign idx_last = (idx_q == SLOT_MAX);
    assign out_fire = buf_valid_q && i_gray_ready;
    assign o_accept = !buf_valid_q || (idx_last && i_gray_ready);

    //////////////////////////////////////////////////
    // Flags follow the two lane stages.
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld1_q  <= 1'b0;
            vld2_q  <= 1'b0;
            last1_q <= 1'b0;
            last2_q <= 1'b0;
        end else if (o_accept) begin
            vld1_q  <= i_group_valid;
            vld2_q  <= vld1_q;
            last1_q <= i_group_last;
            last2_q <= last1_q;
        end
    end

    //////////////////////////////////////////////////
    // Group buffer and serializer.
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (o_accept && vld2_q) begin
            buf_q <= i_group;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            buf_valid_q <= 1'b0;
            buf_last_q  <= 1'b0;
            idx_q       <= '0;
        end else if (o_accept) begin
            buf_valid_q <= vld2_q;
            buf_last_q  <= last2_q;
            idx_q       <= '0;
        end else if (out_fire) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    always_comb begin
        o_gray.gray = buf_q.gray[idx_q];
        o_gray.bw   = buf_q.bw[idx_q];
        o_gray.last = buf_last_q && idx_last;
    end

    assign o_gray_valid = buf_valid_q;

    // Dark count and end of frame.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dark_q <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= out_fire && o_gray.last;
            if (i_start) begin
                dark_q <= '0;
            end else if (out_fire && o_gray.bw) begin
                dark_q <= dark_q + 1'b1;
            end
        end
    end

    assign o_frame_done = done_q;
    assign o_dark_count = dark_q;

endmodule

// ==== verilog/img_gray_top.sv ====
`include "img_gray_params.svh"

module img_gray_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  img_gray_pkg::apb_req_t      i_apb,
    output img_gray_pkg::apb_rsp_t      o_apb,
    input  img_gray_pkg::rgb_pixel_t    i_pix,
    input  logic                        i_pix_valid,
    output logic                        o_pix_ready,
    output img_gray_pkg::gray_pixel_t   o_gray,
    output logic                        o_gray_valid,
    input  logic                        i_gray_ready
);

    import img_gray_pkg::*;

    logic                                            start;
    logic [`IMG_GRAY_CNT_W-1:0]                      pixel_count;
    logic [`IMG_GRAY_PIX_W-1:0]                      threshold;
    logic                                            frame_done;
    logic [`IMG_GRAY_CNT_W-1:0]                      dark_count;
    logic                                            accept;
    lane_group_t                                     group;
    logic                                            group_valid;
    logic                                            group_last;
    logic [`IMG_GRAY_LANES-1:0][`IMG_GRAY_PIX_W-1:0] lane_gray;
    logic [`IMG_GRAY_LANES-1:0]                      lane_bw;
    gray_group_t                                     lane_res;

    img_gray_apb_regs u_regs (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_apb         (i_apb),
        .o_apb         (o_apb),
        .o_start       (start),
        .o_pixel_count (pixel_count),
        .o_threshold   (threshold),
        .i_frame_done  (frame_done),
        .i_dark_count  (dark_count)
    );

    img_gray_fetch u_fetch (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (start),
        .i_pixel_count (pixel_count),
        .i_pix         (i_pix),
        .i_pix_valid   (i_pix_valid),
        .o_pix_ready   (o_pix_ready),
        .i_accept      (accept),
        .o_group       (group),
        .o_group_valid (group_valid),
        .o_group_last  (group_last)
    );

    // One lane per pixel of the group.
    for (genvar k = 0; k < `IMG_GRAY_LANES; k++) begin : g_lane
        gray_lane u_lane (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_advance   (accept),
            .i_pix       (group[k]),
            .i_threshold (threshold),
            .o_gray      (lane_gray[k]),
            .o_bw        (lane_bw[k])
        );
    end

    assign lane_res.gray = lane_gray;
    assign lane_res.bw   = lane_bw;

    img_gray_collect u_collect (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (start),
        .i_group       (lane_res),
        .i_group_valid (group_valid),
        .i_group_last  (group_last),
        .o_accept      (accept),
        .o_gray        (o_gray),
        .o_gray_valid  (o_gray_valid),
        .i_gray_ready  (i_gray_ready),
        .o_frame_done  (frame_done),
        .o_dark_count  (dark_count)
    );

endmodule

// ==== dv/img_gray_tb.sv ====
`include "img_gray_params.svh"

module img_gray_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import img_gray_pkg::*;

    localparam int MAX_PIX = 16;
    localparam int NUM_FRAMES = 4;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * MAX_PIX * 40 + 2000;
    localparam int PIX_BASE = 4;
    localparam int PIX_WORDS = 6;
    localparam logic [31:0] SEED = 32'h9e91;

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    rgb_pixel_t  pix;
    logic        pix_valid;
    logic        pix_ready;
    gray_pixel_t gray;
    logic        gray_valid;
    logic        gray_ready;

    // Four header words first, then six words per pixel.
    logic [31:0] pat [0:PIX_BASE + PIX_WORDS * MAX_PIX - 1];
    logic [31:0] gap_rng;
    logic [31:0] stall_rng;
    int          error_count;
    int          test_errors;
    int          tests_passed;
    int          test_num;

    img_gray_top i_img_gray_top (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_apb        (apb_req),
        .o_apb        (apb_rsp),
        .i_pix        (pix),
        .i_pix_valid  (pix_valid),
        .o_pix_ready  (pix_ready),
        .o_gray       (gray),
        .o_gray_valid (gray_valid),
        .i_gray_ready (gray_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped making progress", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    //////////////////////////////////////////////////
    // Helpers.
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic rgb_pixel_t pixel_at(input int i);
        rgb_pixel_t p;
        p.red   = pat[PIX_BASE + PIX_WORDS * i][`IMG_GRAY_PIX_W-1:0];
        p.green = pat[PIX_BASE + PIX_WORDS * i + 1][`IMG_GRAY_PIX_W-1:0];
        p.blue  = pat[PIX_BASE + PIX_WORDS * i + 2][`IMG_GRAY_PIX_W-1:0];
        return p;
    endfunction

    function automatic logic bw_at(input int i, input bit thr_b);
        return pat[PIX_BASE + PIX_WORDS * i + 4 + int'(thr_b)][0];
    endfunction

    function automatic gray_pixel_t expected_at(input int i, input bit thr_b, input int npix);
        gray_pixel_t g;
        g.gray = pat[PIX_BASE + PIX_WORDS * i + 3][`IMG_GRAY_PIX_W-1:0];
        g.bw   = bw_at(i, thr_b);
        g.last = (i == npix - 1);
        return g;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s: expected %h, got %h", name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (test_errors == 0) begin
            tests_passed++;
        end
        $display("test %0d, %s: %0d errors", test_num, name, test_errors);
        test_errors = 0;
    endtask

    // Setup and access phases, then one idle cycle.
    task automatic apb_transfer(input bit write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        check_value("pready", 32'h1, apb_rsp.pready);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata, err);
        check_value("pslverr", 32'h0, err);
    endtask

    task automatic reg_check(input logic [7:0] addr, input string name,
                             input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr, 32'h0, rdata, err);
        check_value("pslverr", 32'h0, err);
        check_value(name, expected, rdata);
    endtask

    //////////////////////////////////////////////////
    // Stream processes.
    //////////////////////////////////////////////////

    task automatic drive_pixels(input int npix, input bit random_flow);
        int i;
        for (i = 0; i < npix; i++) begin
            if (random_flow) begin
                gap_rng = xorshift32(gap_rng);
                while (gap_rng[1:0] == 2'b00) begin
                    pix_valid = 1'b0;
                    @(negedge clk);
                    gap_rng = xorshift32(gap_rng);
                end
            end
            pix       = pixel_at(i);
            pix_valid = 1'b1;
            @(posedge clk);
            while (!pix_ready) begin
                @(posedge clk);
            end
            @(negedge clk);
        end
        pix_valid = 1'b0;
    endtask

    task automatic check_output(input int npix, input bit thr_b, input bit random_flow);
        gray_pixel_t exp;
        int          i;
        i = 0;
        while (i < npix) begin
            if (random_flow) begin
                stall_rng  = xorshift32(stall_rng);
                gray_ready = (stall_rng[1:0] != 2'b00);
            end else begin
                gray_ready = 1'b1;
            end
            @(posedge clk);
            if (gray_valid && gray_ready) begin
                exp = expected_at(i, thr_b, npix);
                check_value("o_gray.gray", exp.gray, gray.gray);
                check_value("o_gray.bw", exp.bw, gray.bw);
                check_value("o_gray.last", exp.last, gray.last);
                i++;
            end
            @(negedge clk);
        end
        gray_ready = 1'b1;
    endtask

    task automatic run_frame(input bit thr_b, input bit random_flow, input int npix);
        logic [31:0] rdata;
        logic        err;
        int          dark;
        int          i;
        dark = 0;
        for (i = 0; i < npix; i++) begin
            dark += bw_at(i, thr_b);
        end
        reg_write(`IMG_GRAY_ADDR_CTRL, 32'h1);
        reg_check(`IMG_GRAY_ADDR_STATUS, "STATUS", 32'h1);
        fork
            drive_pixels(npix, random_flow);
            check_output(npix, thr_b, random_flow);
        join
        // Poll until the frame reports done.
        rdata = 32'h0;
        while (!rdata[1]) begin
            apb_transfer(1'b0, `IMG_GRAY_ADDR_STATUS, 32'h0, rdata, err);
        end
        check_value("STATUS", 32'h2, rdata);
        check_value("o_gray_valid", 32'h0, gray_valid);
        check_value("o_pix_ready", 32'h0, pix_ready);
        reg_check(`IMG_GRAY_ADDR_DARK, "DARK", dark);
    endtask

    //////////////////////////////////////////////////
    // Test sequence.
    //////////////////////////////////////////////////

    initial begin : main
        logic [31:0] rdata;
        logic        err;
        int          npix;
        rst_n        = 1'b0;
        apb_req      = '0;
        pix          = '0;
        pix_valid    = 1'b0;
        gray_ready   = 1'b1;
        gap_rng      = SEED;
        stall_rng    = xorshift32(SEED);
        error_count  = 0;
        test_errors  = 0;
        tests_passed = 0;
        test_num     = 0;
        $readmemh("dv/img_gray_patterns.txt", pat);
        npix = pat[0] - pat[0] % `IMG_GRAY_LANES;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        check_value("o_pix_ready", 32'h0, pix_ready);
        check_value("o_gray_valid", 32'h0, gray_valid);
        reg_check(`IMG_GRAY_ADDR_STATUS, "STATUS", 32'h0);
        reg_check(`IMG_GRAY_ADDR_DARK, "DARK", 32'h0);
        reg_write(`IMG_GRAY_ADDR_COUNT, pat[0]);
        reg_check(`IMG_GRAY_ADDR_COUNT, "COUNT", pat[0]);
        reg_write(`IMG_GRAY_ADDR_THRESH, pat[1]);
        reg_check(`IMG_GRAY_ADDR_THRESH, "THRESH", pat[1]);
        apb_transfer(1'b0, 8'h14, 32'h0, rdata, err);
        check_value("pslverr", 32'h1, err);
        apb_transfer(1'b1, 8'h40, 32'h1, rdata, err);
        check_value("pslverr", 32'h1, err);
        finish_test("register access");

        run_frame(1'b0, 1'b0, npix);
        finish_test("conversion");

        reg_write(`IMG_GRAY_ADDR_THRESH, pat[2]);
        run_frame(1'b1, 1'b0, npix);
        finish_test("threshold");

        reg_write(`IMG_GRAY_ADDR_THRESH, pat[1]);
        run_frame(1'b0, 1'b1, npix);
        finish_test("back-pressure");

        // Only whole groups of an uneven count are converted.
        reg_write(`IMG_GRAY_ADDR_COUNT, pat[3]);
        reg_check(`IMG_GRAY_ADDR_COUNT, "COUNT", pat[3]);
        reg_write(`IMG_GRAY_ADDR_THRESH, pat[2]);
        run_frame(1'b1, 1'b1, pat[3] - pat[3] % `IMG_GRAY_LANES);
        finish_test("frame end");

        $display("%0d of %0d tests passed, %0d checks failed",
                 tests_passed, test_num, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== img_gray.f ====
+incdir+verilog
verilog/img_gray_pkg.sv
verilog/img_gray_apb_regs.sv
verilog/img_gray_fetch.sv
verilog/gray_lane.sv
verilog/img_gray_collect.sv
verilog/img_gray_top.sv
dv/img_gray_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module img_gray_tb -f img_gray.f -o img_gray_sim &&
    ./obj_dir/img_gray_sim | tee /dev/stderr | grep -q "All tests passed!" &&
    echo "Simulation run: PASS" ||
    { echo "Simulation run: FAIL"; exit 1; }

// ==== dv/img_gray_patterns.txt ====
// First line: pixel count, threshold A, threshold B, uneven pixel count (hex).
// Pixel lines: red, green, blue, expected gray, bw at threshold A, bw at threshold B.
010 0c8 1f4 011
// Black, then full-scale white which saturates.
000 000 000 000 1 1
3ff 3ff 3ff 3ff 0 0
// Single channels at full scale.
3ff 000 000 12f 0 1
000 3ff 000 257 0 0
000 000 3ff 093 1 1
// Mid gray and mixed colors.
200 200 200 20e 0 0
064 0c8 12c 0bd 1 1
12c 0c8 064 0dc 0 1
0c8 0c8 0c8 0cc 0 1
// Gray equal to threshold A counts as dark.
0c4 0c4 0c4 0c8 1 1
320 258 190 285 0 0
040 080 100 083 1 1
// Sum of terms above 1023.
3e8 3e8 3e8 3ff 0 0
384 1f4 064 23d 0 0
190 12c 032 12c 0 1
003 005 007 003 1 1
